//--- hdl/tmu_geom_pkg.sv
// geometry types for the texture address unit, imported by scanner, address pipe, FIFO and fetch
package tmu_geom_pkg;

	////////////////////////////////////////
	// scalar widths
	////////////////////////////////////////

	// integer pixel coordinate, also used for horizontal resolution
	typedef logic [10:0] coord_t;
	// texture coordinate or step, 11.6 fixed point
	typedef logic [16:0] tcoord_t;
	// sub-texel fraction
	typedef logic [5:0]  frac_t;
	// word address, one word per 16-bit pixel
	typedef logic [24:0] wadr_t;

	////////////////////////////////////////
	// grouped signals
	////////////////////////////////////////

	// one pixel from the scanner
	typedef struct packed {
		coord_t  dx;
		coord_t  dy;
		tcoord_t tx;
		tcoord_t ty;
	} point_t;

	// addresses for one pixel
	// texels a b on the top row, c d one texture line below
	typedef struct packed {
		wadr_t dadr;
		wadr_t tadra;
		wadr_t tadrb;
		wadr_t tadrc;
		wadr_t tadrd;
		frac_t x_frac;
		frac_t y_frac;
	} bundle_t;

	// rectangle command
	typedef struct packed {
		coord_t  x0;
		coord_t  y0;
		coord_t  width;
		coord_t  height;
		tcoord_t tx0;
		tcoord_t ty0;
		tcoord_t dtx;
		tcoord_t dty;
	} rect_cmd_t;

	// frame buffer setup, held stable while busy
	typedef struct packed {
		wadr_t  dst_fbuf;
		wadr_t  tex_fbuf;
		coord_t dst_hres;
		coord_t tex_hres;
	} fb_cfg_t;

endpackage

//--- hdl/tmu_bus_pkg.sv
// bus side types for the texture address unit, used by the fetch unit and the top level ports
package tmu_bus_pkg;

	// one 16-bit pixel
	typedef logic [15:0] texel_t;

	////////////////////////////////////////
	// wishbone classic, read only
	////////////////////////////////////////

	// master to slave, no write path so no we
	typedef struct packed {
		logic                cyc;
		logic                stb;
		tmu_geom_pkg::wadr_t adr;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic   ack;
		texel_t dat;
	} wb_rsp_t;

	// fragment handed out of the unit
	typedef struct packed {
		tmu_geom_pkg::wadr_t dadr;
		texel_t              tex_a;
		texel_t              tex_b;
		texel_t              tex_c;
		texel_t              tex_d;
		tmu_geom_pkg::frac_t x_frac;
		tmu_geom_pkg::frac_t y_frac;
	} frag_t;

endpackage

//--- hdl/tmu_scan.sv
// rectangle scanner, walks a command in raster order and offers one point per pixel
`timescale 1ns/1ps

module tmu_scan (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  logic                   start_i,
	input  tmu_geom_pkg::rect_cmd_t cmd_i,
	output logic                   busy_o,
	output logic                   pt_stb_o,
	input  logic                   pt_ack_i,
	output tmu_geom_pkg::point_t   pt_o
);
	import tmu_geom_pkg::*;

	typedef enum logic {
		st_idle,
		st_run
	} scan_state_t;

	scan_state_t state;

	// latched command
	rect_cmd_t cmd_q;
	// position inside the rectangle
	coord_t    col;
	coord_t    row;
	// running texture coordinates
	tcoord_t   tx;
	tcoord_t   ty;

	logic      last_col;
	logic      last_row;
	logic      step;

	assign last_col = (col == (cmd_q.width - 11'd1));
	assign last_row = (row == (cmd_q.height - 11'd1));
	// point leaves this cycle
	assign step = pt_stb_o & pt_ack_i;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					// zero width or height gives nothing to draw
					if (start_i && (cmd_i.width != '0) && (cmd_i.height != '0))
						state <= st_run;
				end
				st_run: begin
					if (step && last_col && last_row)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////
	// counters and accumulators
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (state == st_idle) begin
			cmd_q <= cmd_i;
			col   <= '0;
			row   <= '0;
			tx    <= cmd_i.tx0;
			ty    <= cmd_i.ty0;
		end else if (step) begin
			if (last_col) begin
				// next row, back to left edge
				col <= '0;
				row <= row + 11'd1;
				tx  <= cmd_q.tx0;
				ty  <= ty + cmd_q.dty;
			end else begin
				col <= col + 11'd1;
				tx  <= tx + cmd_q.dtx;
			end
		end
	end

	// outputs
	assign busy_o   = (state == st_run);
	assign pt_stb_o = (state == st_run);
	assign pt_o.dx  = cmd_q.x0 + col;
	assign pt_o.dy  = cmd_q.y0 + row;
	assign pt_o.tx  = tx;
	assign pt_o.ty  = ty;

endmodule

//--- hdl/tmu_adrgen.sv
// address pipeline, turns a point into destination and four texel word addresses
`timescale 1ns/1ps

module tmu_adrgen (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  tmu_geom_pkg::fb_cfg_t cfg_i,
	input  logic                  pt_stb_i,
	output logic                  pt_ack_o,
	input  tmu_geom_pkg::point_t  pt_i,
	output logic                  bnd_stb_o,
	input  logic                  bnd_ack_i,
	output tmu_geom_pkg::bundle_t bnd_o,
	output logic                  busy_o
);
	import tmu_geom_pkg::*;

	// one enable for all three stages
	logic    pipe_en;

	// stage 1, multiply
	logic    valid_1;
	wadr_t   dadr_1;
	wadr_t   tadra_1;
	frac_t   x_frac_1;
	frac_t   y_frac_1;

	// stage 2, delay for the multiplier
	logic    valid_2;
	wadr_t   dadr_2;
	wadr_t   tadra_2;
	frac_t   x_frac_2;
	frac_t   y_frac_2;

	// stage 3, neighbour texels
	logic    valid_3;
	bundle_t bnd_3;

	////////////////////////////////////////
	// valid chain
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_1 <= 1'b0;
			valid_2 <= 1'b0;
			valid_3 <= 1'b0;
		end else if (pipe_en) begin
			valid_1 <= pt_stb_i;
			valid_2 <= valid_1;
			valid_3 <= valid_2;
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (pipe_en) begin
			dadr_1   <= cfg_i.dst_fbuf + wadr_t'(cfg_i.dst_hres) * wadr_t'(pt_i.dy)
				+ wadr_t'(pt_i.dx);
			// integer part of the texture point
			tadra_1  <= cfg_i.tex_fbuf + wadr_t'(cfg_i.tex_hres) * wadr_t'(pt_i.ty[16:6])
				+ wadr_t'(pt_i.tx[16:6]);
			x_frac_1 <= pt_i.tx[5:0];
			y_frac_1 <= pt_i.ty[5:0];

			dadr_2   <= dadr_1;
			tadra_2  <= tadra_1;
			x_frac_2 <= x_frac_1;
			y_frac_2 <= y_frac_1;

			// right, below and below right of texel a
			bnd_3.dadr   <= dadr_2;
			bnd_3.tadra  <= tadra_2;
			bnd_3.tadrb  <= tadra_2 + 25'd1;
			bnd_3.tadrc  <= tadra_2 + wadr_t'(cfg_i.tex_hres);
			bnd_3.tadrd  <= tadra_2 + wadr_t'(cfg_i.tex_hres) + 25'd1;
			bnd_3.x_frac <= x_frac_2;
			bnd_3.y_frac <= y_frac_2;
		end
	end

	// advance while the output slot is free or leaving
	assign pipe_en   = ~valid_3 | bnd_ack_i;
	assign pt_ack_o  = pipe_en;
	assign bnd_stb_o = valid_3;
	assign bnd_o     = bnd_3;
	assign busy_o    = valid_1 | valid_2 | valid_3;

endmodule

//--- hdl/tmu_adr_fifo.sv
// synchronous fall-through FIFO between the address pipeline and the texel fetch
`timescale 1ns/1ps

module tmu_adr_fifo #(
	parameter int fifo_depth_log2 = 3
) (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  wr_stb_i,
	output logic                  wr_ack_o,
	input  tmu_geom_pkg::bundle_t wr_i,
	output logic                  rd_stb_o,
	input  logic                  rd_ack_i,
	output tmu_geom_pkg::bundle_t rd_o,
	output logic                  empty_o
);
	import tmu_geom_pkg::*;

	bundle_t                    mem [1 << fifo_depth_log2];
	logic [fifo_depth_log2-1:0] wr_ptr;
	logic [fifo_depth_log2-1:0] rd_ptr;
	// one extra bit, msb set only when full
	logic [fifo_depth_log2:0]   count;

	logic                       wr_en;
	logic                       rd_en;

	assign wr_ack_o = ~count[fifo_depth_log2];
	assign empty_o  = (count == '0);
	assign rd_stb_o = ~empty_o;
	assign wr_en    = wr_stb_i & wr_ack_o;
	assign rd_en    = rd_stb_o & rd_ack_i;

	// head entry shown without a read request
	assign rd_o = mem[rd_ptr];

	always_ff @(posedge sys_clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_i;
	end

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous read and write leaves count alone
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- hdl/tmu_fetch.sv
// texel fetch, reads four texels per bundle over wishbone and presents the fragment
`timescale 1ns/1ps

module tmu_fetch (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  bnd_stb_i,
	output logic                  bnd_ack_o,
	input  tmu_geom_pkg::bundle_t bnd_i,
	output tmu_bus_pkg::wb_req_t  wb_o,
	input  tmu_bus_pkg::wb_rsp_t  wb_i,
	output logic                  frag_stb_o,
	input  logic                  frag_ack_i,
	output tmu_bus_pkg::frag_t    frag_o,
	output logic                  busy_o
);
	import tmu_geom_pkg::*;
	import tmu_bus_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_present
	} fetch_state_t;

	fetch_state_t state;
	// texel being read, a to d
	logic [1:0]   idx;
	bundle_t      bnd_q;
	texel_t       tex_q [4];
	wb_req_t      req;
	wadr_t        cur_adr;

	// address of the current texel
	always_comb begin
		case (idx)
			2'd0:    cur_adr = bnd_q.tadra;
			2'd1:    cur_adr = bnd_q.tadrb;
			2'd2:    cur_adr = bnd_q.tadrc;
			default: cur_adr = bnd_q.tadrd;
		endcase
	end

	////////////////////////////////////////
	// control and bus cycle
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state   <= st_idle;
			idx     <= 2'd0;
			req.cyc <= 1'b0;
			req.stb <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (bnd_stb_i) begin
						state <= st_read;
						idx   <= 2'd0;
					end
				end
				st_read: begin
					if (req.stb) begin
						// hold until the slave answers
						if (wb_i.ack) begin
							req.cyc <= 1'b0;
							req.stb <= 1'b0;
							if (idx == 2'd3)
								state <= st_present;
							else
								idx <= idx + 2'd1;
						end
					end else begin
						// one idle cycle between reads
						req.cyc <= 1'b1;
						req.stb <= 1'b1;
					end
				end
				st_present: begin
					if (frag_ack_i)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////

	always_ff @(posedge sys_clk) begin
		if (bnd_stb_i && bnd_ack_o)
			bnd_q <= bnd_i;
		// address set on the cycle cyc and stb rise
		if ((state == st_read) && !req.stb)
			req.adr <= cur_adr;
		if (req.stb && wb_i.ack)
			tex_q[idx] <= wb_i.dat;
	end

	assign bnd_ack_o = (state == st_idle);
	assign busy_o    = (state != st_idle);
	assign wb_o      = req;

	// fragment out
	assign frag_stb_o    = (state == st_present);
	assign frag_o.dadr   = bnd_q.dadr;
	assign frag_o.tex_a  = tex_q[0];
	assign frag_o.tex_b  = tex_q[1];
	assign frag_o.tex_c  = tex_q[2];
	assign frag_o.tex_d  = tex_q[3];
	assign frag_o.x_frac = bnd_q.x_frac;
	assign frag_o.y_frac = bnd_q.y_frac;

endmodule

//--- hdl/tmu_addr_unit.sv
// texture address unit top level, scanner to address pipe to FIFO to texel fetch
`timescale 1ns/1ps

module tmu_addr_unit #(
	parameter int fifo_depth_log2 = 3
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst,
	input  logic                    start_i,
	input  tmu_geom_pkg::rect_cmd_t cmd_i,
	input  tmu_geom_pkg::fb_cfg_t   cfg_i,
	output logic                    busy_o,
	output tmu_bus_pkg::wb_req_t    wb_o,
	input  tmu_bus_pkg::wb_rsp_t    wb_i,
	output logic                    frag_stb_o,
	input  logic                    frag_ack_i,
	output tmu_bus_pkg::frag_t      frag_o
);
	import tmu_geom_pkg::*;

	// busy flags
	logic    scan_busy;
	logic    adr_busy;
	logic    fetch_busy;
	logic    fifo_empty;

	// command taken only when everything is drained
	logic    start_ok;

	// scanner to address pipe
	logic    pt_stb;
	logic    pt_ack;
	point_t  pt;

	// address pipe to FIFO
	logic    gen_stb;
	logic    gen_ack;
	bundle_t gen_bnd;

	// FIFO to fetch
	logic    rd_stb;
	logic    rd_ack;
	bundle_t rd_bnd;

	assign start_ok = start_i & ~busy_o;
	assign busy_o   = scan_busy | adr_busy | fetch_busy | ~fifo_empty;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	tmu_scan u_scan (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.start_i  (start_ok),
		.cmd_i    (cmd_i),
		.busy_o   (scan_busy),
		.pt_stb_o (pt_stb),
		.pt_ack_i (pt_ack),
		.pt_o     (pt)
	);

	tmu_adrgen u_adrgen (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.cfg_i     (cfg_i),
		.pt_stb_i  (pt_stb),
		.pt_ack_o  (pt_ack),
		.pt_i      (pt),
		.bnd_stb_o (gen_stb),
		.bnd_ack_i (gen_ack),
		.bnd_o     (gen_bnd),
		.busy_o    (adr_busy)
	);

	tmu_adr_fifo #(
		.fifo_depth_log2 (fifo_depth_log2)
	) u_adr_fifo (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.wr_stb_i (gen_stb),
		.wr_ack_o (gen_ack),
		.wr_i     (gen_bnd),
		.rd_stb_o (rd_stb),
		.rd_ack_i (rd_ack),
		.rd_o     (rd_bnd),
		.empty_o  (fifo_empty)
	);

	tmu_fetch u_fetch (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.bnd_stb_i  (rd_stb),
		.bnd_ack_o  (rd_ack),
		.bnd_i      (rd_bnd),
		.wb_o       (wb_o),
		.wb_i       (wb_i),
		.frag_stb_o (frag_stb_o),
		.frag_ack_i (frag_ack_i),
		.frag_o     (frag_o),
		.busy_o     (fetch_busy)
	);

endmodule

//--- verification/tmu_assert.sv
// protocol assertions for the texture address unit, bound into the top level by the testbench
`timescale 1ns/1ps

module tmu_assert (
	input logic                 sys_clk,
	input logic                 sys_rst,
	input tmu_bus_pkg::wb_req_t wb_o,
	input tmu_bus_pkg::wb_rsp_t wb_i,
	input logic                 frag_stb_o,
	input logic                 frag_ack_i,
	input tmu_bus_pkg::frag_t   frag_o
);
	// failed assertions so far, read by the testbench
	int fail_cnt = 0;

	// no strobe outside a bus cycle
	a_stb_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_o.stb |-> wb_o.cyc)
	else begin
		$error("wishbone stb high without cyc");
		fail_cnt++;
	end

	// address frozen while the slave has not answered
	a_adr_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(wb_o.stb && !wb_i.ack) |=> (wb_o.stb && $stable(wb_o.adr)))
	else begin
		$error("wishbone stb or adr changed before ack");
		fail_cnt++;
	end

	// fragment held until taken
	a_frag_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(frag_stb_o && !frag_ack_i) |=> (frag_stb_o && $stable(frag_o)))
	else begin
		$error("fragment strobe or data changed before ack");
		fail_cnt++;
	end

endmodule

//--- verification/tmu_tb.sv
// directed testbench for the texture address unit, with texel memory model and reference queue
`timescale 1ns/1ps

module tmu_tb;
	import tmu_geom_pkg::*;
	import tmu_bus_pkg::*;

	// pixels over all tests, worst case cycles per pixel
	localparam int total_px   = 69;
	localparam int px_cycles  = 64;
	localparam int test_slack = 200;
	localparam int num_tests  = 5;

	logic      sys_clk = 1'b0;
	logic      sys_rst = 1'b1;
	logic      start_i = 1'b0;
	rect_cmd_t cmd_i   = '0;
	fb_cfg_t   cfg     = '0;
	logic      busy;
	wb_req_t   wb_req;
	wb_rsp_t   wb_rsp   = '0;
	logic      frag_stb;
	logic      frag_ack = 1'b0;
	frag_t     frag;

	// reference fragments, oldest first
	frag_t       exp_q[$];
	int          err_cnt   = 0;
	int          frag_cnt  = 0;
	int          fail_tests = 0;
	logic        bp_mode   = 1'b0;
	logic [31:0] lfsr_q    = 32'h1df6aa87;
	// memory model state
	logic        wb_pending = 1'b0;
	logic [1:0]  wait_cnt   = '0;

	always #4 sys_clk = ~sys_clk;

	tmu_addr_unit #(
		.fifo_depth_log2 (3)
	) u_tmu_addr_unit (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.start_i    (start_i),
		.cmd_i      (cmd_i),
		.cfg_i      (cfg),
		.busy_o     (busy),
		.wb_o       (wb_req),
		.wb_i       (wb_rsp),
		.frag_stb_o (frag_stb),
		.frag_ack_i (frag_ack),
		.frag_o     (frag)
	);

	bind tmu_addr_unit tmu_assert u_assert (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.wb_o       (wb_o),
		.wb_i       (wb_i),
		.frag_stb_o (frag_stb_o),
		.frag_ack_i (frag_ack_i),
		.frag_o     (frag_o)
	);

	////////////////////////////////////////
	// random bits and memory contents
	////////////////////////////////////////

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// texel stored at a word address
	// upper address bits folded into the low half
	function automatic texel_t texel_of(input wadr_t adr);
		return adr[15:0] ^ {7'd0, adr[24:16]} ^ 16'h5a5a;
	endfunction

	////////////////////////////////////////
	// wishbone slave and fragment sink
	////////////////////////////////////////

	// registered ack plus 0 to 3 wait states
	always @(posedge sys_clk) begin : mem_model
		logic [31:0] v;
		if (sys_rst) begin
			wb_rsp     <= '0;
			wb_pending <= 1'b0;
			frag_ack   <= 1'b0;
		end else begin
			// ack bit drawn first, keeps the draw order fixed
			draw_bits(1, v);
			frag_ack <= bp_mode ? v[0] : 1'b1;
			if (wb_rsp.ack) begin
				wb_rsp.ack <= 1'b0;
			end else if (wb_req.cyc && wb_req.stb) begin
				if (!wb_pending) begin
					draw_bits(2, v);
					wb_pending <= 1'b1;
					wait_cnt   <= v[1:0];
				end else if (wait_cnt == 2'd0) begin
					wb_rsp.ack <= 1'b1;
					wb_rsp.dat <= texel_of(wb_req.adr);
					wb_pending <= 1'b0;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

	// every accepted fragment checked against the queue head
	always @(posedge sys_clk) begin
		if (!sys_rst && frag_stb && frag_ack) begin
			frag_cnt++;
			if (exp_q.size() == 0) begin
				$display("fragment arrived with no fragment expected");
				err_cnt++;
			end else begin
				cmp_frag(frag, exp_q.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic cmp_wadr(input string name, input wadr_t got, input wadr_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic cmp_texel(input string name, input texel_t got, input texel_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic cmp_frag(input frag_t got, input frag_t exp);
		cmp_wadr("frag_o.dadr", got.dadr, exp.dadr);
		cmp_texel("frag_o.tex_a", got.tex_a, exp.tex_a);
		cmp_texel("frag_o.tex_b", got.tex_b, exp.tex_b);
		cmp_texel("frag_o.tex_c", got.tex_c, exp.tex_c);
		cmp_texel("frag_o.tex_d", got.tex_d, exp.tex_d);
		if ({got.x_frac, got.y_frac} !== {exp.x_frac, exp.y_frac}) begin
			$display("MISMATCH frag_o.x_frac/y_frac got %h %h expected %h %h",
				got.x_frac, got.y_frac, exp.x_frac, exp.y_frac);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// raster order, texture step added per column and per row
	task automatic model_rect(input rect_cmd_t c);
		frag_t   f;
		coord_t  dx;
		coord_t  dy;
		tcoord_t tx;
		tcoord_t ty;
		wadr_t   ta;
		for (int r = 0; r < int'(c.height); r++) begin
			for (int k = 0; k < int'(c.width); k++) begin
				dx = c.x0 + coord_t'(k);
				dy = c.y0 + coord_t'(r);
				tx = c.tx0 + tcoord_t'(k) * c.dtx;
				ty = c.ty0 + tcoord_t'(r) * c.dty;
				ta = cfg.tex_fbuf + wadr_t'(cfg.tex_hres) * wadr_t'(ty[16:6])
					+ wadr_t'(tx[16:6]);
				f.dadr   = cfg.dst_fbuf + wadr_t'(cfg.dst_hres) * wadr_t'(dy) + wadr_t'(dx);
				f.tex_a  = texel_of(ta);
				f.tex_b  = texel_of(ta + 25'd1);
				f.tex_c  = texel_of(ta + wadr_t'(cfg.tex_hres));
				f.tex_d  = texel_of(ta + wadr_t'(cfg.tex_hres) + 25'd1);
				f.x_frac = tx[5:0];
				f.y_frac = ty[5:0];
				exp_q.push_back(f);
			end
		end
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	function automatic rect_cmd_t rect(input coord_t x0, input coord_t y0, input coord_t w,
		input coord_t h, input tcoord_t tx0, input tcoord_t ty0, input tcoord_t dtx,
		input tcoord_t dty);
		rect_cmd_t c;
		c.x0     = x0;
		c.y0     = y0;
		c.width  = w;
		c.height = h;
		c.tx0    = tx0;
		c.ty0    = ty0;
		c.dtx    = dtx;
		c.dty    = dty;
		return c;
	endfunction

	function automatic int errors_now();
		return err_cnt + u_tmu_addr_unit.u_assert.fail_cnt;
	endfunction

	task automatic apply_reset();
		@(posedge sys_clk);
		sys_rst <= 1'b1;
		repeat (5) @(posedge sys_clk);
		sys_rst <= 1'b0;
	endtask

	// one cycle start pulse
	task automatic start_rect(input rect_cmd_t c);
		@(posedge sys_clk);
		cmd_i   <= c;
		start_i <= 1'b1;
		@(posedge sys_clk);
		start_i <= 1'b0;
	endtask

	// until all expected fragments are in and busy drops
	task automatic wait_done();
		@(negedge sys_clk);
		while (exp_q.size() != 0 || busy) begin
			if (exp_q.size() != 0 && !busy) begin
				$display("busy_o dropped with %0d fragments outstanding", exp_q.size());
				err_cnt++;
				break;
			end
			@(negedge sys_clk);
		end
	endtask

	task automatic report_test(input string name, input int base, input int px);
		if (frag_cnt != px) begin
			$display("%s received %0d fragments instead of %0d", name, frag_cnt, px);
			err_cnt++;
		end
		if (errors_now() == base) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: %0d errors", name, errors_now() - base);
			fail_tests++;
		end
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic run_rect(input string name, input rect_cmd_t c, input logic bp);
		int base;
		base     = errors_now();
		bp_mode  = bp;
		frag_cnt = 0;
		model_rect(c);
		start_rect(c);
		wait_done();
		repeat (10) @(negedge sys_clk);
		report_test(name, base, int'(c.width) * int'(c.height));
	endtask

	// second start while busy must be dropped
	task automatic busy_test();
		int        base;
		rect_cmd_t c;
		base     = errors_now();
		bp_mode  = 1'b0;
		frag_cnt = 0;
		apply_reset();
		@(negedge sys_clk);
		if (busy) begin
			$display("busy_o high after reset");
			err_cnt++;
		end
		c = rect(11'd3, 11'd7, 11'd3, 11'd2, {11'd2, 6'd0}, {11'd4, 6'd0}, 17'h40, 17'h40);
		model_rect(c);
		start_rect(c);
		@(negedge sys_clk);
		if (!busy) begin
			$display("busy_o did not rise after start");
			err_cnt++;
		end
		// first fragment out means the scanner is already idle
		while (frag_cnt == 0)
			@(negedge sys_clk);
		if (!busy) begin
			$display("busy_o low with fragments outstanding");
			err_cnt++;
		end
		start_rect(rect(11'd0, 11'd0, 11'd5, 11'd5, '0, '0, 17'h40, 17'h40));
		wait_done();
		repeat (30) @(negedge sys_clk);
		report_test("busy_idle", base, 6);
	endtask

	// watchdog sized from the pixel count
	initial begin
		#((total_px * px_cycles + num_tests * test_slack) * 8);
		$display("watchdog expired, unit stopped producing fragments");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		cfg.dst_fbuf = 25'h0010000;
		cfg.tex_fbuf = 25'h0100000;
		cfg.dst_hres = 11'd640;
		cfg.tex_hres = 11'd256;
		apply_reset();

		// 1x1, fractional start point
		run_rect("single_pixel",
			rect(11'd37, 11'd21, 11'd1, 11'd1, {11'd5, 6'd17}, {11'd9, 6'd40}, 17'h40, 17'h40),
			1'b0);
		// 4x3, steps 1.0 and 2.0
		run_rect("raster_walk",
			rect(11'd100, 11'd50, 11'd4, 11'd3, {11'd10, 6'd0}, {11'd20, 6'd0}, 17'h40, 17'h80),
			1'b0);
		// steps 0.25 and 0.75, carries into the integer part
		run_rect("frac_steps",
			rect(11'd9, 11'd300, 11'd6, 11'd3, {11'd3, 6'd40}, {11'd7, 6'd30}, 17'h10, 17'h30),
			1'b0);
		// random fragment ack
		run_rect("back_pressure",
			rect(11'd600, 11'd2, 11'd8, 11'd4, {11'd1, 6'd5}, {11'd60, 6'd9}, 17'h20, 17'h60),
			1'b1);
		busy_test();

		$display("tests %0d, failed %0d, errors %0d", num_tests, fail_tests, errors_now());
		if (errors_now() == 0 && fail_tests == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- tb.f
hdl/tmu_geom_pkg.sv
hdl/tmu_bus_pkg.sv
hdl/tmu_scan.sv
hdl/tmu_adrgen.sv
hdl/tmu_adr_fifo.sv
hdl/tmu_fetch.sv
hdl/tmu_addr_unit.sv
verification/tmu_assert.sv
verification/tmu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tmu_tb
FLIST      ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
